/* core_pkg.sv */
// RV32I core package
// Word types, decode enums, bus and pipeline structs, reset vector

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // Major opcodes of the supported instructions
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        K_ALU, K_LOAD, K_STORE, K_BRANCH_EQ, K_BRANCH_NE, K_JAL, K_NOP
    } instr_kind_e;

    // ------------------------------------------------------------------
    // Bus structs
    // ------------------------------------------------------------------
    typedef struct packed {
        logic  cyc;
        logic  we;
        word_t adr;
        word_t wdat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdat;
    } wb_rsp_t;

    // ------------------------------------------------------------------
    // Pipeline structs
    // ------------------------------------------------------------------
    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t       pc;
        instr_kind_e kind;
        alu_op_e     alu_op;
        word_t       a;
        word_t       b;
        word_t       sdata;
        word_t       imm;
        reg_addr_t   rd;
        logic        we;
    } id_ex_t;

    typedef struct packed {
        instr_kind_e kind;
        word_t       result;
        word_t       sdata;
        reg_addr_t   rd;
        logic        we;
    } ex_mem_t;

endpackage

/* core_regfile.sv */
// Register file
// 31 general registers, x0 reads as zero, two read ports and one
// write port with write-to-read bypass

`timescale 1ns/10ps

module core_regfile (
    input  logic               clk,
    input  logic               rst_i,
    input  core_pkg::reg_addr_t rs1_i,
    input  core_pkg::reg_addr_t rs2_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    input  logic               we_i,
    input  core_pkg::reg_addr_t rd_i,
    input  core_pkg::word_t     rd_data_i
);

    core_pkg::word_t regs_q [1:31];

    function automatic core_pkg::word_t read_port(core_pkg::reg_addr_t ra);
        core_pkg::word_t val;
        if (ra == '0) begin
            val = '0;
        end else if (we_i && rd_i == ra) begin
            // Same-cycle write returns the new value
            val = rd_data_i;
        end else begin
            val = regs_q[ra];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

endmodule

/* core_if_stage.sv */
// Instruction fetch stage
// Holds the PC, reads one instruction per bus cycle and keeps it in a
// one-deep buffer until decode takes it

`timescale 1ns/10ps

module core_if_stage (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             halt_i,
    input  logic             redirect_i,
    input  core_pkg::word_t   redirect_pc_i,
    input  logic             ack_i,
    output logic             valid_o,
    output core_pkg::if_id_t  out_o,
    output core_pkg::wb_req_t ibus_req_o,
    input  core_pkg::wb_rsp_t ibus_rsp_i
);

    typedef enum logic [1:0] {IF_IDLE, IF_WAIT_ACK, IF_HOLD} if_state_e;

    if_state_e       state_q;
    core_pkg::word_t pc_q;
    core_pkg::word_t adr_q;
    core_pkg::word_t fetch_pc;
    logic            cyc_q;
    logic            drop_q;

    // Read-only master
    assign ibus_req_o = '{cyc: cyc_q, we: 1'b0, adr: adr_q, wdat: '0};

    assign fetch_pc = redirect_i ? redirect_pc_i : pc_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IF_IDLE;
            pc_q    <= core_pkg::RESET_PC;
            cyc_q   <= 1'b0;
            drop_q  <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end
            case (state_q)
                IF_IDLE: begin
                    if (!halt_i) begin
                        cyc_q   <= 1'b1;
                        adr_q   <= fetch_pc;
                        state_q <= IF_WAIT_ACK;
                    end
                end
                IF_WAIT_ACK: begin
                    // Outstanding read becomes stale on a redirect
                    if (redirect_i) begin
                        drop_q <= 1'b1;
                    end
                    if (ibus_rsp_i.ack) begin
                        cyc_q  <= 1'b0;
                        drop_q <= 1'b0;
                        if (drop_q || redirect_i) begin
                            state_q <= IF_IDLE;
                        end else begin
                            out_o   <= '{pc: adr_q, instr: ibus_rsp_i.rdat};
                            valid_o <= 1'b1;
                            pc_q    <= pc_q + 32'd4;
                            state_q <= IF_HOLD;
                        end
                    end
                end
                IF_HOLD: begin
                    if (redirect_i) begin
                        valid_o <= 1'b0;
                        state_q <= IF_IDLE;
                    end else if (ack_i) begin
                        // Buffer freed, next read goes out straight away
                        valid_o <= 1'b0;
                        cyc_q   <= 1'b1;
                        adr_q   <= pc_q;
                        state_q <= IF_WAIT_ACK;
                    end
                end
                default: state_q <= IF_IDLE;
            endcase
        end
    end

endmodule

/* core_id_stage.sv */
// Instruction decode stage
// Decodes the fetched word, builds the immediate and operand b, and
// stalls on source or destination registers that await write-back

`timescale 1ns/10ps

module core_id_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               halt_i,
    input  logic               flush_i,
    input  logic               valid_i,
    output logic               ack_o,
    input  core_pkg::if_id_t    in_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    input  logic               wb_we_i,
    input  core_pkg::reg_addr_t wb_rd_i,
    output logic               valid_o,
    input  logic               ack_i,
    output core_pkg::id_ex_t    out_o
);

    core_pkg::word_t       ins;
    core_pkg::word_t       imm;
    core_pkg::reg_addr_t   rd;
    core_pkg::instr_kind_e kind;
    core_pkg::alu_op_e     alu_op;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_imm;
    logic                  dec_we;
    logic                  hazard;
    logic                  issue;
    logic [31:0]           pending_q;

    assign ins        = in_i.instr;
    assign rd         = ins[11:7];
    assign rs1_addr_o = ins[19:15];
    assign rs2_addr_o = ins[24:20];

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    always_comb begin
        kind    = core_pkg::K_NOP;
        alu_op  = core_pkg::ALU_ADD;
        imm     = {{20{ins[31]}}, ins[31:20]};
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b1;
        case (ins[6:0])
            core_pkg::OPC_OP_IMM: begin
                if (ins[14:12] == 3'b000) begin
                    kind    = core_pkg::K_ALU;
                    use_rs1 = 1'b1;
                end
            end
            core_pkg::OPC_OP: begin
                kind    = core_pkg::K_ALU;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_imm = 1'b0;
                case (ins[14:12])
                    3'b000:  alu_op = ins[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b111:  alu_op = core_pkg::ALU_AND;
                    3'b110:  alu_op = core_pkg::ALU_OR;
                    3'b100:  alu_op = core_pkg::ALU_XOR;
                    default: kind   = core_pkg::K_NOP;
                endcase
            end
            core_pkg::OPC_LUI: begin
                kind   = core_pkg::K_ALU;
                alu_op = core_pkg::ALU_PASS_B;
                imm    = {ins[31:12], 12'b0};
            end
            core_pkg::OPC_LOAD: begin
                if (ins[14:12] == 3'b010) begin
                    kind    = core_pkg::K_LOAD;
                    use_rs1 = 1'b1;
                end
            end
            core_pkg::OPC_STORE: begin
                if (ins[14:12] == 3'b010) begin
                    kind    = core_pkg::K_STORE;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            core_pkg::OPC_BRANCH: begin
                if (ins[14:13] == 2'b00) begin
                    kind    = ins[12] ? core_pkg::K_BRANCH_NE : core_pkg::K_BRANCH_EQ;
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                end
                use_imm = 1'b0;
                imm     = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            core_pkg::OPC_JAL: begin
                kind = core_pkg::K_JAL;
                imm  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: kind = core_pkg::K_NOP;
        endcase
    end

    assign dec_we = (kind == core_pkg::K_ALU || kind == core_pkg::K_LOAD ||
                     kind == core_pkg::K_JAL) && rd != '0;

    // ------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------
    function automatic logic busy(core_pkg::reg_addr_t r);
        // A register written back this cycle reads through the bypass
        return pending_q[r] && !(wb_we_i && wb_rd_i == r);
    endfunction

    always_comb begin
        hazard = (use_rs1 && busy(rs1_addr_o)) ||
                 (use_rs2 && busy(rs2_addr_o)) ||
                 (dec_we && busy(rd));
    end

    assign ack_o = !halt_i && !hazard && (!valid_o || ack_i);
    assign issue = valid_i && ack_o && !flush_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pending_q <= '0;
        end else begin
            if (wb_we_i) begin
                pending_q[wb_rd_i] <= 1'b0;
            end
            if (issue && dec_we) begin
                pending_q[rd] <= 1'b1;
            end
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (issue) begin
            valid_o <= 1'b1;
        end else if (ack_i) begin
            valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            out_o <= '{pc: in_i.pc, kind: kind, alu_op: alu_op, a: rs1_data_i,
                       b: use_imm ? imm : rs2_data_i, sdata: rs2_data_i,
                       imm: imm, rd: rd, we: dec_we};
        end
    end

endmodule

/* core_ex_stage.sv */
// Execute stage
// ALU, load/store address, JAL link value and branch resolution with
// a redirect to fetch when a branch is taken

`timescale 1ns/10ps

module core_ex_stage (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             halt_i,
    input  logic             valid_i,
    output logic             ack_o,
    input  core_pkg::id_ex_t  in_i,
    output logic             valid_o,
    input  logic             ack_i,
    output core_pkg::ex_mem_t out_o,
    output logic             redirect_o,
    output core_pkg::word_t   redirect_pc_o
);

    core_pkg::word_t alu_res;
    core_pkg::word_t result;
    logic            taken;

    always_comb begin
        case (in_i.alu_op)
            core_pkg::ALU_SUB:    alu_res = in_i.a - in_i.b;
            core_pkg::ALU_AND:    alu_res = in_i.a & in_i.b;
            core_pkg::ALU_OR:     alu_res = in_i.a | in_i.b;
            core_pkg::ALU_XOR:    alu_res = in_i.a ^ in_i.b;
            core_pkg::ALU_PASS_B: alu_res = in_i.b;
            default:              alu_res = in_i.a + in_i.b;
        endcase

        case (in_i.kind)
            core_pkg::K_LOAD, core_pkg::K_STORE: result = in_i.a + in_i.imm;
            core_pkg::K_JAL:                     result = in_i.pc + 32'd4;
            default:                             result = alu_res;
        endcase

        // Operand b carries rs2 for branches
        case (in_i.kind)
            core_pkg::K_BRANCH_EQ: taken = (in_i.a == in_i.b);
            core_pkg::K_BRANCH_NE: taken = (in_i.a != in_i.b);
            core_pkg::K_JAL:       taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    assign ack_o = !halt_i && (!valid_o || ack_i);

    // Redirect in the cycle the branch is taken over
    assign redirect_o    = valid_i && ack_o && taken;
    assign redirect_pc_o = in_i.pc + in_i.imm;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (ack_o) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ack_o) begin
            out_o <= '{kind: in_i.kind, result: result, sdata: in_i.sdata,
                       rd: in_i.rd, we: in_i.we};
        end
    end

endmodule

/* core_mem_stage.sv */
// Memory and write-back stage
// Runs the data bus cycle for LW and SW and writes load data or
// results into the register file

`timescale 1ns/10ps

module core_mem_stage (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               halt_i,
    input  logic               valid_i,
    output logic               ack_o,
    input  core_pkg::ex_mem_t   in_i,
    output core_pkg::wb_req_t   dbus_req_o,
    input  core_pkg::wb_rsp_t   dbus_rsp_i,
    output logic               rf_we_o,
    output core_pkg::reg_addr_t rf_rd_o,
    output core_pkg::word_t     rf_data_o
);

    typedef enum logic {MEM_IDLE, MEM_BUS} mem_state_e;

    mem_state_e state_q;
    logic       take;
    logic       is_mem;
    logic       ld_we_q;

    assign ack_o  = !halt_i && (state_q == MEM_IDLE);
    assign take   = valid_i && ack_o;
    assign is_mem = (in_i.kind == core_pkg::K_LOAD) || (in_i.kind == core_pkg::K_STORE);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q        <= MEM_IDLE;
            dbus_req_o.cyc <= 1'b0;
            rf_we_o        <= 1'b0;
        end else begin
            rf_we_o <= 1'b0;
            case (state_q)
                MEM_IDLE: begin
                    if (take && is_mem) begin
                        dbus_req_o.cyc <= 1'b1;
                        state_q        <= MEM_BUS;
                    end else if (take) begin
                        rf_we_o <= in_i.we;
                    end
                end
                MEM_BUS: begin
                    if (dbus_rsp_i.ack) begin
                        // Stores carry a cleared write enable
                        dbus_req_o.cyc <= 1'b0;
                        rf_we_o        <= ld_we_q;
                        state_q        <= MEM_IDLE;
                    end
                end
                default: state_q <= MEM_IDLE;
            endcase
        end
    end

    // Bus fields and write-back payload
    always_ff @(posedge clk) begin
        if (take) begin
            dbus_req_o.we   <= (in_i.kind == core_pkg::K_STORE);
            dbus_req_o.adr  <= in_i.result;
            dbus_req_o.wdat <= in_i.sdata;
            ld_we_q         <= in_i.we;
            rf_rd_o         <= in_i.rd;
            rf_data_o       <= in_i.result;
        end else if (state_q == MEM_BUS && dbus_rsp_i.ack) begin
            rf_data_o <= dbus_rsp_i.rdat;
        end
    end

endmodule

/* core_top.sv */
// RV32I core top level
// Wires fetch, decode, execute and memory stages to the register file
// and brings out the instruction and data bus ports

`timescale 1ns/10ps

module core_top (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             halt_core_i,
    output core_pkg::wb_req_t ibus_req_o,
    input  core_pkg::wb_rsp_t ibus_rsp_i,
    output core_pkg::wb_req_t dbus_req_o,
    input  core_pkg::wb_rsp_t dbus_rsp_i
);

    // Stage handshakes
    logic                if_valid;
    logic                id_ack;
    core_pkg::if_id_t    if_id;
    logic                id_valid;
    logic                ex_ack;
    core_pkg::id_ex_t    id_ex;
    logic                ex_valid;
    logic                mem_ack;
    core_pkg::ex_mem_t   ex_mem;

    // Taken branch or jump
    logic                redirect;
    core_pkg::word_t     redirect_pc;

    // Register file ports
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    logic                rf_we;
    core_pkg::reg_addr_t rf_rd;
    core_pkg::word_t     rf_data;

    core_regfile u_regfile (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_i      (rs1_addr),
        .rs2_i      (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (rf_rd),
        .rd_data_i  (rf_data)
    );

    core_if_stage u_if (
        .clk           (clk),
        .rst_i         (rst_i),
        .halt_i        (halt_core_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .ack_i         (id_ack),
        .valid_o       (if_valid),
        .out_o         (if_id),
        .ibus_req_o    (ibus_req_o),
        .ibus_rsp_i    (ibus_rsp_i)
    );

    core_id_stage u_id (
        .clk        (clk),
        .rst_i      (rst_i),
        .halt_i     (halt_core_i),
        .flush_i    (redirect),
        .valid_i    (if_valid),
        .ack_o      (id_ack),
        .in_i       (if_id),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .wb_we_i    (rf_we),
        .wb_rd_i    (rf_rd),
        .valid_o    (id_valid),
        .ack_i      (ex_ack),
        .out_o      (id_ex)
    );

    core_ex_stage u_ex (
        .clk           (clk),
        .rst_i         (rst_i),
        .halt_i        (halt_core_i),
        .valid_i       (id_valid),
        .ack_o         (ex_ack),
        .in_i          (id_ex),
        .valid_o       (ex_valid),
        .ack_i         (mem_ack),
        .out_o         (ex_mem),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    core_mem_stage u_mem (
        .clk        (clk),
        .rst_i      (rst_i),
        .halt_i     (halt_core_i),
        .valid_i    (ex_valid),
        .ack_o      (mem_ack),
        .in_i       (ex_mem),
        .dbus_req_o (dbus_req_o),
        .dbus_rsp_i (dbus_rsp_i),
        .rf_we_o    (rf_we),
        .rf_rd_o    (rf_rd),
        .rf_data_o  (rf_data)
    );

endmodule

/* core_asserts.sv */
// Core protocol assertions
// Bus request stability until ack, bus idle after reset, and no new
// bus cycle while the core is halted

`timescale 1ns/10ps

module core_asserts (
    input logic              clk,
    input logic              rst_i,
    input logic              halt_i,
    input core_pkg::wb_req_t ibus_req_i,
    input core_pkg::wb_rsp_t ibus_rsp_i,
    input core_pkg::wb_req_t dbus_req_i,
    input core_pkg::wb_rsp_t dbus_rsp_i
);

    int unsigned err_cnt = 0;

    // ------------------------------------------------------------------
    // Request held until the slave acks
    // ------------------------------------------------------------------
    ibus_hold: assert property (@(posedge clk) disable iff (rst_i)
        ibus_req_i.cyc && !ibus_rsp_i.ack |=> $stable(ibus_req_i))
        else begin
            err_cnt = err_cnt + 1;
            $error("ibus request changed before ack");
        end

    dbus_hold: assert property (@(posedge clk) disable iff (rst_i)
        dbus_req_i.cyc && !dbus_rsp_i.ack |=> $stable(dbus_req_i))
        else begin
            err_cnt = err_cnt + 1;
            $error("dbus request changed before ack");
        end

    // Both buses idle once reset has been seen
    reset_idle: assert property (@(posedge clk)
        rst_i |=> !ibus_req_i.cyc && !dbus_req_i.cyc)
        else begin
            err_cnt = err_cnt + 1;
            $error("bus cycle active after reset");
        end

    // Halt blocks new bus cycles
    halt_ibus: assert property (@(posedge clk) disable iff (rst_i)
        halt_i && !ibus_req_i.cyc |=> !ibus_req_i.cyc)
        else begin
            err_cnt = err_cnt + 1;
            $error("ibus cycle started during halt");
        end

    halt_dbus: assert property (@(posedge clk) disable iff (rst_i)
        halt_i && !dbus_req_i.cyc |=> !dbus_req_i.cyc)
        else begin
            err_cnt = err_cnt + 1;
            $error("dbus cycle started during halt");
        end

endmodule

bind core_top core_asserts u_core_asserts (
    .clk        (clk),
    .rst_i      (rst_i),
    .halt_i     (halt_core_i),
    .ibus_req_i (ibus_req_o),
    .ibus_rsp_i (ibus_rsp_i),
    .dbus_req_i (dbus_req_o),
    .dbus_rsp_i (dbus_rsp_i)
);

/* tb_core_top.sv */
// Testbench for the RV32I pipeline core
// Instruction and data memory models with random ack latency, a fixed
// program covering every supported instruction, and store checking
// against the expected RV32I results

`timescale 1ns/10ps

module tb_core_top;

    logic              clk = 1'b0;
    logic              rst_i;
    logic              halt_core;
    core_pkg::wb_req_t ibus_req;
    core_pkg::wb_rsp_t ibus_rsp;
    core_pkg::wb_req_t dbus_req;
    core_pkg::wb_rsp_t dbus_rsp;

    core_pkg::word_t   imem [0:63];
    core_pkg::word_t   dmem [0:63];
    core_pkg::word_t   exp_adr [$];
    core_pkg::word_t   exp_dat [$];
    int unsigned       store_idx = 0;
    int                i_wait = -1;
    int                d_wait = -1;

    always #50 clk = ~clk;

    core_top UUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .halt_core_i (halt_core),
        .ibus_req_o  (ibus_req),
        .ibus_rsp_i  (ibus_rsp),
        .dbus_req_o  (dbus_req),
        .dbus_rsp_i  (dbus_rsp)
    );

    // ------------------------------------------------------------------
    // Instruction encoders
    // ------------------------------------------------------------------
    function automatic core_pkg::word_t alu_rr(input int f7, input int f3, input int rd,
                                               input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic core_pkg::word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic core_pkg::word_t lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic core_pkg::word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic core_pkg::word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t branch(input int f3, input int rs1, input int rs2,
                                               input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic core_pkg::word_t jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // ------------------------------------------------------------------
    // Program and expected stores
    // ------------------------------------------------------------------
    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            // Filler is a NOP carrying its own word index
            imem[i] = addi(0, 0, i);
            dmem[i] = 32'h5A00_0000 ^ (core_pkg::word_t'(i) << 2);
        end
        dmem[16] = 32'hCAFE_F00D;
        imem[0]  = addi(1, 0, 5);
        imem[1]  = addi(2, 1, 7);
        imem[2]  = alu_rr(0, 0, 3, 1, 2);
        imem[3]  = alu_rr('h20, 0, 4, 2, 1);
        imem[4]  = alu_rr(0, 7, 5, 3, 4);
        imem[5]  = alu_rr(0, 6, 6, 3, 4);
        imem[6]  = alu_rr(0, 4, 7, 3, 4);
        imem[7]  = lui(8, 'h12345);
        imem[8]  = addi(8, 8, 'h678);
        imem[9]  = addi(9, 0, 'h40);
        imem[10] = lw(10, 9, 0);
        imem[11] = addi(11, 0, 'h80);
        imem[12] = sw(3, 11, 0);
        imem[13] = sw(4, 11, 4);
        imem[14] = sw(5, 11, 8);
        imem[15] = sw(6, 11, 12);
        imem[16] = sw(7, 11, 16);
        imem[17] = sw(8, 11, 20);
        imem[18] = sw(10, 11, 24);
        imem[19] = alu_rr(0, 0, 12, 10, 1);
        imem[20] = sw(12, 11, 28);
        // Three passes of the BNE loop
        imem[21] = addi(13, 0, 3);
        imem[22] = addi(14, 0, 0);
        imem[23] = addi(14, 14, 10);
        imem[24] = addi(13, 13, -1);
        imem[25] = branch(1, 13, 0, -8);
        imem[26] = sw(14, 11, 32);
        // Taken BEQ over a poison ADDI
        imem[27] = branch(0, 13, 0, 8);
        imem[28] = addi(14, 0, 'h7FF);
        imem[29] = sw(14, 11, 36);
        // JAL over a poison store and a poison ADDI
        imem[30] = jal(15, 12);
        imem[31] = sw(0, 11, 64);
        imem[32] = addi(15, 0, 1);
        imem[33] = sw(15, 11, 40);
        imem[34] = jal(0, 0);
    endtask

    task automatic expect_store(input core_pkg::word_t adr, input core_pkg::word_t dat);
        exp_adr.push_back(adr);
        exp_dat.push_back(dat);
    endtask

    task automatic load_expected();
        expect_store(32'h80, 32'd17);          // 5 + 12
        expect_store(32'h84, 32'd7);           // 12 - 5
        expect_store(32'h88, 32'd1);           // 17 & 7
        expect_store(32'h8C, 32'd23);          // 17 | 7
        expect_store(32'h90, 32'd22);          // 17 ^ 7
        expect_store(32'h94, 32'h1234_5678);   // LUI plus ADDI
        expect_store(32'h98, 32'hCAFE_F00D);   // Loaded word
        expect_store(32'h9C, 32'hCAFE_F012);   // Loaded word + 5
        expect_store(32'hA0, 32'd30);          // Loop sum
        expect_store(32'hA4, 32'd30);          // Poison skipped
        expect_store(32'hA8, 32'h0000_007C);   // JAL link, pc 0x78 + 4
    endtask

    // ------------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t expv,
                              input core_pkg::word_t actv);
        assert (actv == expv) else
            fail_run($sformatf("ERROR: %s expected 0x%08h actual 0x%08h", name, expv, actv));
    endtask

    task automatic record_store(input core_pkg::word_t adr, input core_pkg::word_t dat);
        if (store_idx >= exp_adr.size()) begin
            fail_run($sformatf("Unexpected store to address 0x%08h", adr));
        end else begin
            check_word("dbus_req_o.adr", exp_adr[store_idx], adr);
            check_word("dbus_req_o.wdat", exp_dat[store_idx], dat);
            store_idx++;
        end
    endtask

    task automatic wait_stores(input int unsigned count, input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (store_idx < count && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (store_idx < count) begin
            fail_run($sformatf("Timed out after %0d cycles with %0d of %0d stores seen",
                               limit, store_idx, count));
        end
    endtask

    // ------------------------------------------------------------------
    // Bus slave models, answering on the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_i || ibus_rsp.ack || !ibus_req.cyc) begin
            ibus_rsp.ack = 1'b0;
            i_wait       = -1;
        end else begin
            if (i_wait < 0) begin
                i_wait = int'($urandom_range(3, 0));
            end
            if (i_wait == 0) begin
                ibus_rsp.ack  = 1'b1;
                ibus_rsp.rdat = imem[ibus_req.adr[7:2]];
            end
            i_wait = i_wait - 1;
        end
    end

    always @(negedge clk) begin
        if (rst_i || dbus_rsp.ack || !dbus_req.cyc) begin
            dbus_rsp.ack = 1'b0;
            d_wait       = -1;
        end else begin
            if (d_wait < 0) begin
                d_wait = int'($urandom_range(3, 0));
            end
            if (d_wait == 0) begin
                dbus_rsp.ack = 1'b1;
                if (dbus_req.we) begin
                    record_store(dbus_req.adr, dbus_req.wdat);
                    dmem[dbus_req.adr[7:2]] = dbus_req.wdat;
                end else begin
                    dbus_rsp.rdat = dmem[dbus_req.adr[7:2]];
                end
            end
            d_wait = d_wait - 1;
        end
    end

    // Protocol assertion failures end the run
    always @(negedge clk) begin
        if (UUT.u_core_asserts.err_cnt != 0) begin
            fail_run("A bus protocol assertion failed");
        end
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int unsigned span;
        void'($urandom(67));
        rst_i     = 1'b1;
        halt_core = 1'b0;
        ibus_rsp  = '0;
        dbus_rsp  = '0;
        load_program();
        load_expected();
        repeat (8) @(negedge clk);
        rst_i = 1'b0;

        // Freeze the core part way through the store sequence
        wait_stores(3, 2000);
        @(negedge clk);
        halt_core = 1'b1;
        span = $urandom_range(24, 4);
        repeat (span) @(negedge clk);
        halt_core = 1'b0;

        wait_stores(exp_adr.size(), 4000);
        // Window for any stray store after the last one
        repeat (40) @(negedge clk);

        if (UUT.u_core_asserts.err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run("Assertion failures were recorded");
        end
    end

endmodule

/* verilog.f */
core_pkg.sv
core_regfile.sv
core_if_stage.sv
core_id_stage.sv
core_ex_stage.sv
core_mem_stage.sv
core_top.sv
core_asserts.sv
tb_core_top.sv

/* Makefile */
SIM       := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_core_top
FILELIST  := verilog.f
RUN_FLAGS := +verilator+error+limit+100
BIN       := obj_dir/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
